//--- Makefile
# Verilator build and run of the MIPS multiply test

VERILATOR ?= verilator
TOP       ?= mips_system_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram import mips_pkg::*; (
    input  logic       clk,
    // cpu side
    input  logic       dmem_we,
    input  dmem_addr_t dmem_addr,
    input  word_t      dmem_wdata,
    output word_t      dmem_rdata,
    // external load and readback
    input  logic       load_we,
    input  dmem_addr_t load_addr,
    input  word_t      load_wdata,
    input  dmem_addr_t peek_addr,
    output word_t      peek_rdata
);

    word_t mem [0:dmem_words-1];

    // one write per edge
    // cpu store wins over an external load in the same cycle
    always_ff @(posedge clk) begin
        if (dmem_we) begin
            mem[dmem_addr] <= dmem_wdata;
        end else if (load_we) begin
            mem[load_addr] <= load_wdata;
        end
    end

    // lw data, same cycle as the address
    assign dmem_rdata = mem[dmem_addr];

    // readback port, always live
    assign peek_rdata = mem[peek_addr];

endmodule

//--- hdl/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu import mips_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    output logic       busy,
    output logic       done,
    output word_t      instr_address,
    input  word_t      instr_readdata,
    output reg_idx_t   rs_idx,
    output reg_idx_t   rt_idx,
    input  word_t      rs_data,
    input  word_t      rt_data,
    output logic       wr_en,
    output reg_idx_t   wr_idx,
    output word_t      wr_data,
    output logic       mult_en,
    input  word_t      hi,
    input  word_t      lo,
    output logic       dmem_we,
    output dmem_addr_t dmem_addr,
    output word_t      dmem_wdata,
    input  word_t      dmem_rdata
);

    cpu_state_t state;
    word_t      pc;
    // jr target, taken after the delay slot
    word_t      jump_target;

    // instruction fields
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rd_idx;
    word_t      imm_sext;
    // rs + imm for lw, sw and addiu
    word_t      addr_sum;

    // decoded instruction, anything else falls through as a nop
    logic is_special;
    logic is_lw;
    logic is_sw;
    logic is_addiu;
    logic is_mult;
    logic is_mflo;
    logic is_mfhi;
    logic is_jr;

    assign instr_address = pc;

    assign opcode   = instr_readdata[31:26];
    assign rs_idx   = instr_readdata[25:21];
    assign rt_idx   = instr_readdata[20:16];
    assign rd_idx   = instr_readdata[15:11];
    assign funct    = instr_readdata[5:0];
    assign imm_sext = {{16{instr_readdata[15]}}, instr_readdata[15:0]};

    assign is_special = (opcode == op_special);
    assign is_lw      = (opcode == op_lw);
    assign is_sw      = (opcode == op_sw);
    assign is_addiu   = (opcode == op_addiu);
    assign is_mult    = is_special && (funct == fn_mult);
    assign is_mflo    = is_special && (funct == fn_mflo);
    assign is_mfhi    = is_special && (funct == fn_mfhi);
    assign is_jr      = is_special && (funct == fn_jr);

    assign addr_sum = rs_data + imm_sext;

    // word access only, low two address bits dropped
    assign dmem_addr  = addr_sum[10:2];
    assign dmem_wdata = rt_data;

    // strobes only while a run is in progress
    assign busy    = (state != s_idle);
    assign dmem_we = busy && is_sw;
    assign mult_en = busy && is_mult;
    assign wr_en   = busy && (is_lw || is_addiu || is_mflo || is_mfhi);

    // r-type moves write rd, i-type writes rt
    assign wr_idx = (is_mflo || is_mfhi) ? rd_idx : rt_idx;

    // writeback select
    always_comb begin
        if (is_lw) begin
            wr_data = dmem_rdata;
        end else if (is_mflo) begin
            wr_data = lo;
        end else if (is_mfhi) begin
            wr_data = hi;
        end else begin
            wr_data = addr_sum;
        end
    end

    // run control and pc
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            pc    <= reset_vector;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    // start during a run never reaches here
                    if (start) begin
                        pc    <= reset_vector;
                        state <= s_run;
                    end
                end
                s_run: begin
                    pc <= pc + 32'd4;
                    if (is_jr) begin
                        state <= s_slot;
                    end
                end
                s_slot: begin
                    // slot instruction executes on this edge, then halt
                    pc    <= jump_target;
                    state <= s_idle;
                    done  <= 1'b1;
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == s_run) && is_jr) begin
            jump_target <= rs_data;
        end
    end

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

    // data and instruction words
    typedef logic [31:0] word_t;
    // register number, r0..r31
    typedef logic [4:0]  reg_idx_t;
    // word index into the 512-word data memory
    typedef logic [8:0]  dmem_addr_t;
    // word index into the 4096-word instruction rom
    typedef logic [11:0] imem_addr_t;

    // pc loaded on start, the rom folds its address around this
    localparam word_t reset_vector = 32'hbfc0_0000;

    localparam int dmem_words = 512;
    localparam int imem_words = 4096;

    // primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;
    localparam logic [5:0] op_addiu   = 6'b001001;

    // funct codes under op_special
    localparam logic [5:0] fn_mult = 6'b011000;
    localparam logic [5:0] fn_mflo = 6'b010010;
    localparam logic [5:0] fn_mfhi = 6'b010000;
    localparam logic [5:0] fn_jr   = 6'b001000;

    // run control
    // s_slot executes the delay slot instruction after jr
    typedef enum logic [1:0] {
        s_idle,
        s_run,
        s_slot
    } cpu_state_t;

endpackage

//--- hdl/mips_system.sv
`timescale 1ns/1ps

module mips_system import mips_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic       load_we,
    input  dmem_addr_t load_addr,
    input  word_t      load_wdata,
    input  dmem_addr_t peek_addr,
    output word_t      peek_rdata,
    output logic       busy,
    output logic       done
);

    // fetch
    word_t instr_address;
    word_t instr_readdata;

    // register file
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    // multiplier
    logic  mult_en;
    word_t hi;
    word_t lo;

    // data memory, cpu side
    logic       dmem_we;
    dmem_addr_t dmem_addr;
    word_t      dmem_wdata;
    word_t      dmem_rdata;

    mips_cpu u_cpu (
        .clk            (clk),
        .arst_n         (arst_n),
        .start          (start),
        .busy           (busy),
        .done           (done),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .rs_idx         (rs_idx),
        .rt_idx         (rt_idx),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .wr_en          (wr_en),
        .wr_idx         (wr_idx),
        .wr_data        (wr_data),
        .mult_en        (mult_en),
        .hi             (hi),
        .lo             (lo),
        .dmem_we        (dmem_we),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_rdata     (dmem_rdata)
    );

    mult_1_iram u_iram (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    reg_file u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    // operands come straight from the register read ports
    mult_unit u_mult (
        .clk     (clk),
        .arst_n  (arst_n),
        .mult_en (mult_en),
        .op_a    (rs_data),
        .op_b    (rt_data),
        .hi      (hi),
        .lo      (lo)
    );

    data_ram u_dram (
        .clk        (clk),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_wdata (load_wdata),
        .peek_addr  (peek_addr),
        .peek_rdata (peek_rdata)
    );

endmodule

//--- hdl/mult_1_iram.sv
`timescale 1ns/1ps

module mult_1_iram import mips_pkg::*; (
    input  word_t instr_address,
    output word_t instr_readdata
);

    word_t rom [0:imem_words-1];

    // address after folding around the reset vector
    word_t      folded;
    imem_addr_t rd_idx;

    // next free word while the program is assembled
    imem_addr_t w_idx;

    // i-type: opcode, rs, rt, immediate
    function automatic word_t i_instr(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                      logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // r-type under op_special, shamt always zero here
    function automatic word_t r_instr(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                      logic [5:0] fn);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    initial begin
        // unused words decode as sll r0, which the core runs as a nop
        for (int n = 0; n < imem_words; n++) begin
            rom[n] = '0;
        end
        w_idx = '0;

        // lw r2..r16 from data words 0..14
        for (int r = 2; r <= 16; r++) begin
            rom[w_idx] = i_instr(op_lw, 5'd0, reg_idx_t'(r), 16'((r - 2) * 4));
            w_idx++;
        end

        // mult neighbouring pair, lo back into the lower register
        // and hi into r17..r30
        for (int r = 3; r <= 16; r++) begin
            rom[w_idx] = r_instr(reg_idx_t'(r - 1), reg_idx_t'(r), 5'd0, fn_mult);
            w_idx++;
            rom[w_idx] = r_instr(5'd0, 5'd0, reg_idx_t'(r - 1), fn_mflo);
            w_idx++;
            rom[w_idx] = r_instr(5'd0, 5'd0, reg_idx_t'(r + 14), fn_mfhi);
            w_idx++;
        end

        // hi at 0x400 + 8k, lo right after it
        for (int k = 0; k < 14; k++) begin
            rom[w_idx] = i_instr(op_sw, 5'd0, reg_idx_t'(17 + k), 16'(16'h400 + k * 8));
            w_idx++;
            rom[w_idx] = i_instr(op_sw, 5'd0, reg_idx_t'(2 + k), 16'(16'h404 + k * 8));
            w_idx++;
        end

        // jr r0 halts the run once the slot has executed
        rom[w_idx] = r_instr(5'd0, 5'd0, 5'd0, fn_jr);
        w_idx++;

        // delay slot: addiu r0, r0, 0 is a nop since r0 is never written
        rom[w_idx] = i_instr(op_addiu, 5'd0, 5'd0, 16'h0000);
    end

    // program starts at word 0 of the rom
    assign folded = instr_address % reset_vector;
    assign rd_idx = folded[13:2];

    // combinational read, same cycle as the fetch address
    assign instr_readdata = rom[rd_idx];

endmodule

//--- hdl/mult_unit.sv
`timescale 1ns/1ps

module mult_unit import mips_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  mult_en,
    input  word_t op_a,
    input  word_t op_b,
    output word_t hi,
    output word_t lo
);

    // full signed product of the two operands
    logic signed [63:0] product;

    assign product = $signed(op_a) * $signed(op_b);

    // hi/lo only change on a mult
    // mflo and mfhi in the next cycle see the new values
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (mult_en) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [0:31];

    // two asynchronous read ports
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    // single write port, r0 never written so it reads zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_en && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

//--- sources.f
hdl/mips_pkg.sv
hdl/mult_1_iram.sv
hdl/mult_unit.sv
hdl/reg_file.sv
hdl/data_ram.sv
hdl/mips_cpu.sv
hdl/mips_system.sv
verification/mips_system_chk.sv
verification/mips_system_tb.sv

//--- verification/mips_system_chk.sv
`timescale 1ns/1ps

module mips_system_chk (
    input logic clk,
    input logic arst_n,
    input logic start,
    input logic busy,
    input logic done
);

    // set once any property fails
    logic fail_seen = 1'b0;

    // done lasts one cycle
    done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            fail_seen = 1'b1;
            $error("done held for more than one cycle");
        end

    // done only after busy has fallen
    done_idle: assert property (@(posedge clk) disable iff (!arst_n) !(done && busy))
        else begin
            fail_seen = 1'b1;
            $error("done high while busy");
        end

    // busy rises only on a start seen in the previous cycle
    busy_start: assert property (@(posedge clk) disable iff (!arst_n) $rose(busy) |-> $past(start))
        else begin
            fail_seen = 1'b1;
            $error("busy rose without start");
        end

endmodule

bind mips_cpu mips_system_chk chk_i (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .busy   (busy),
    .done   (done)
);

//--- verification/mips_system_tb.sv
`timescale 1ns/1ps

module mips_system_tb import mips_pkg::*;;

    // two runs, each loads, peeks, runs, reads results and rechecks inputs
    localparam int runs        = 2;
    localparam int cycle_limit = runs * (15 + 15 + 87 + 28 + 15 + 20);

    logic       clk;
    logic       arst_n;
    logic       start;
    logic       load_we;
    dmem_addr_t load_addr;
    word_t      load_wdata;
    dmem_addr_t peek_addr;
    word_t      peek_rdata;
    logic       busy;
    logic       done;

    // input words and expected hi/lo pairs for the current run
    word_t data_tab [0:14];
    word_t exp_tab  [0:27];

    word_t rng_state;
    int    cycle_count;
    int    done_count;

    mips_system dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_wdata (load_wdata),
        .peek_addr  (peek_addr),
        .peek_rdata (peek_rdata),
        .busy       (busy),
        .done       (done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (done === 1'b1) begin
            done_count <= done_count + 1;
        end
        if (dut_i.u_cpu.chk_i.fail_seen) begin
            $display("run control assertion failed at %0t", $time);
            $display("TEST FAIL");
            $fatal(1, "assertion failure");
        end else if (cycle_count > cycle_limit) begin
            $display("timeout: test still running after %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic word_t xorshift32(input word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // inputs change 5 ns after the edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // small_signed gives 20-bit values, every odd entry negative
    task automatic fill_tables(input bit small_signed);
        int     val;
        int     a;
        int     b;
        longint prod;
        for (int i = 0; i < 15; i++) begin
            rng_state = xorshift32(rng_state);
            if (small_signed) begin
                val = int'(rng_state[19:0]);
                if (i % 2 == 1) begin
                    val = -val - 1;
                end
                data_tab[i] = word_t'(val);
            end else begin
                data_tab[i] = rng_state;
            end
        end
        // hi at word 0x100+2k, lo right after it
        for (int k = 0; k < 14; k++) begin
            a = int'(data_tab[k]);
            b = int'(data_tab[k + 1]);
            prod = longint'(a) * longint'(b);
            exp_tab[2 * k]     = prod[63:32];
            exp_tab[2 * k + 1] = prod[31:0];
        end
    endtask

    task automatic run_program(input bit restart_while_busy);
        int dones_before;
        for (int i = 0; i < 15; i++) begin
            load_we    = 1'b1;
            load_addr  = dmem_addr_t'(i);
            load_wdata = data_tab[i];
            next_cycle();
        end
        load_we = 1'b0;
        for (int i = 0; i < 15; i++) begin
            peek_addr = dmem_addr_t'(i);
            next_cycle();
            check("peek_rdata", peek_rdata, data_tab[i]);
        end
        check("busy", {31'd0, busy}, 32'd0);
        check("done", {31'd0, done}, 32'd0);
        dones_before = done_count;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check("busy", {31'd0, busy}, 32'd1);
        if (restart_while_busy) begin
            // start in the middle of a run is ignored
            repeat (10) next_cycle();
            start = 1'b1;
            next_cycle();
            start = 1'b0;
        end
        while (done !== 1'b1) begin
            next_cycle();
        end
        check("busy", {31'd0, busy}, 32'd0);
        repeat (3) next_cycle();
        check("done", {31'd0, done}, 32'd0);
        check("busy", {31'd0, busy}, 32'd0);
        check("done_count", done_count, dones_before + 1);
        for (int j = 0; j < 28; j++) begin
            peek_addr = dmem_addr_t'(9'h100 + j);
            next_cycle();
            check("peek_rdata", peek_rdata, exp_tab[j]);
        end
        // stores must not touch the input words
        for (int i = 0; i < 15; i++) begin
            peek_addr = dmem_addr_t'(i);
            next_cycle();
            check("peek_rdata", peek_rdata, data_tab[i]);
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        start       = 1'b0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_wdata  = '0;
        peek_addr   = '0;
        rng_state   = 32'd34552;
        cycle_count = 0;
        done_count  = 0;
        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;
        check("busy", {31'd0, busy}, 32'd0);
        check("done", {31'd0, done}, 32'd0);

        fill_tables(1'b0);
        run_program(1'b0);
        fill_tables(1'b1);
        run_program(1'b1);

        if (dut_i.u_cpu.chk_i.fail_seen) begin
            $display("TEST FAIL");
            $fatal(1, "assertion failure");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
